//--- src/UsiPkg.sv
package UsiPkg;

	// --------------------
	// Slave indices
	// --------------------

	// Number of peer slaves on the return bus
	localparam int SlaveCount = 3;
	// Pointer width for the round-robin arbiter
	localparam int SlaveIdxWidth = $clog2(SlaveCount);

	// Bit positions inside every per-slave vector
	localparam int SlaveGpio = 0;
	localparam int SlavePwm = 1;
	localparam int SlaveSram = 2;

	// --------------------
	// CSR register map
	// --------------------

	// Manual registers
	localparam logic [7:0] CsrWd = 8'h00;
	localparam logic [7:0] CsrAdrs = 8'h04;
	localparam logic [7:0] CsrCke = 8'h08;
	localparam logic [7:0] CsrPend = 8'h0C;
	// Auto registers, one per slave
	localparam logic [7:0] CsrGpioRd = 8'h14;
	localparam logic [7:0] CsrPwmRd = 8'h18;
	localparam logic [7:0] CsrSramRd = 8'h1C;
	// Status
	localparam logic [7:0] CsrDone = 8'h3C;
	localparam logic [7:0] CsrRdy = 8'h40;

	// --------------------
	// Bus address word
	// --------------------

	// Set for read, clear for write
	localparam int UsiReadBit = 31;

	// Register selects
	localparam logic [3:0] GpioOut = 4'd0;
	localparam logic [3:0] GpioIn = 4'd1;
	localparam logic [3:0] PwmPeriod = 4'd0;
	localparam logic [3:0] PwmDuty = 4'd1;

	// SRAM geometry
	localparam int SramDepth = 64;
	localparam int SramIdxWidth = $clog2(SramDepth);

	// Two decodes of one address word
	typedef union packed
	{
		// GPIO and PWM view
		struct packed
		{
			logic rd;
			logic [26:0] pad;
			logic [3:0] sel;
		} regs;
		// SRAM view
		struct packed
		{
			logic rd;
			logic [30-SramIdxWidth:0] pad;
			logic [SramIdxWidth-1:0] idx;
		} mem;
	} UsiAdrs_u;

endpackage

//--- src/UsiReturnArbiter.sv
module UsiReturnArbiter
(
	input  logic                          iSysClk,
	input  logic                          rst,
	input  logic [UsiPkg::SlaveCount-1:0] retReq,
	input  logic [31:0]                   gpioRetData,
	input  logic [31:0]                   pwmRetData,
	input  logic [31:0]                   sramRetData,
	output logic [UsiPkg::SlaveCount-1:0] retGnt,
	output logic [31:0]                   usiRd,
	output logic [UsiPkg::SlaveCount-1:0] usiRdCke
);

	// Slave granted most recently
	logic [UsiPkg::SlaveIdxWidth-1:0] lastIdx;
	logic [UsiPkg::SlaveIdxWidth-1:0] gntIdx;
	logic [31:0] gntData;

	// Search starts one past the last winner
	always_comb
	begin
		int idx;
		retGnt = '0;
		gntIdx = lastIdx;
		for (int k = 1; k <= UsiPkg::SlaveCount; k++)
		begin
			idx = (int'(lastIdx) + k) % UsiPkg::SlaveCount;
			if (retReq[idx] && (retGnt == '0))
			begin
				retGnt[idx] = 1'b1;
				gntIdx = idx[UsiPkg::SlaveIdxWidth-1:0];
			end
		end
	end

	// Grant is one-hot so an OR mux is enough
	assign gntData = ({32{retGnt[UsiPkg::SlaveGpio]}} & gpioRetData)
		| ({32{retGnt[UsiPkg::SlavePwm]}} & pwmRetData)
		| ({32{retGnt[UsiPkg::SlaveSram]}} & sramRetData);

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			lastIdx <= '0;
			usiRdCke <= '0;
		end
		else
		begin
			usiRdCke <= retGnt;
			if (|retGnt)
				lastIdx <= gntIdx;
		end
	end

	// Winning word, valid with usiRdCke
	always_ff @(posedge iSysClk)
		usiRd <= gntData;

	aGntOneHot: assert property (@(posedge iSysClk) disable iff (rst) $onehot0(retGnt));
	aGntToReq: assert property (@(posedge iSysClk) disable iff (rst) (retGnt & ~retReq) == '0);
	// Held request gets served before the rotation comes round again
	for (genvar g = 0; g < UsiPkg::SlaveCount; g++)
	begin : gFair
		aNoStarve: assert property (@(posedge iSysClk) disable iff (rst)
			(retReq[g] && !retGnt[g]) |-> ##[1:UsiPkg::SlaveCount] retGnt[g]);
	end

endmodule

//--- src/UsiGpio.sv
module UsiGpio
(
	input  logic        iSysClk,
	input  logic        rst,
	input  logic [31:0] usiWd,
	input  logic [31:0] usiAdrs,
	input  logic        usiCke,
	input  logic        retGnt,
	input  logic [7:0]  gpioIn,
	output logic [7:0]  gpioOut,
	output logic        retReq,
	output logic [31:0] retData,
	output logic        usiRdy
);

	UsiPkg::UsiAdrs_u adrs;
	// Two-flop input sampler
	logic [7:0] inMeta;
	logic [7:0] inSync;
	// Input value carried by the last report
	logic [7:0] lastRpt;
	logic changed;
	logic rdStrobe;
	logic wrStrobe;
	logic [31:0] readWord;
	logic [31:0] reportWord;

	assign adrs = usiAdrs;
	assign rdStrobe = usiCke && adrs.regs.rd;
	assign wrStrobe = usiCke && !adrs.regs.rd;
	assign changed = (inSync != lastRpt);
	// Busy while a return waits or a report is about to be queued
	assign usiRdy = !retReq && !changed;

	always_comb
	begin
		case (adrs.regs.sel)
			UsiPkg::GpioOut: readWord = {24'b0, gpioOut};
			UsiPkg::GpioIn:  readWord = {24'b0, inSync};
			default:         readWord = '0;
		endcase
	end

	// Report marker sits on the read bit position
	always_comb
	begin
		reportWord = {24'b0, inSync};
		reportWord[UsiPkg::UsiReadBit] = 1'b1;
	end

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			inMeta <= '0;
			inSync <= '0;
			lastRpt <= '0;
			gpioOut <= '0;
			retReq <= 1'b0;
		end
		else
		begin
			inMeta <= gpioIn;
			inSync <= inMeta;
			if (wrStrobe && (adrs.regs.sel == UsiPkg::GpioOut))
				gpioOut <= usiWd[7:0];
			// Read reply wins over a report in the same cycle
			if (retReq)
			begin
				if (retGnt)
					retReq <= 1'b0;
			end
			else if (rdStrobe)
				retReq <= 1'b1;
			else if (changed)
			begin
				retReq <= 1'b1;
				lastRpt <= inSync;
			end
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (!retReq && rdStrobe)
			retData <= readWord;
		else if (!retReq && changed)
			retData <= reportWord;
	end

endmodule

//--- src/UsiPwm.sv
module UsiPwm
(
	input  logic        iSysClk,
	input  logic        rst,
	input  logic [31:0] usiWd,
	input  logic [31:0] usiAdrs,
	input  logic        usiCke,
	input  logic        retGnt,
	output logic        retReq,
	output logic [31:0] retData,
	output logic        usiRdy,
	output logic        pwmOut
);

	UsiPkg::UsiAdrs_u adrs;
	logic [15:0] period;
	logic [15:0] duty;
	// Free-running phase counter
	logic [15:0] cnt;
	logic rdStrobe;
	logic wrStrobe;
	logic [31:0] readWord;

	assign adrs = usiAdrs;
	assign rdStrobe = usiCke && adrs.regs.rd;
	assign wrStrobe = usiCke && !adrs.regs.rd;
	assign usiRdy = !retReq;

	always_comb
	begin
		case (adrs.regs.sel)
			UsiPkg::PwmPeriod: readWord = {16'b0, period};
			UsiPkg::PwmDuty:   readWord = {16'b0, duty};
			default:           readWord = '0;
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			period <= '0;
			duty <= '0;
			cnt <= '0;
			pwmOut <= 1'b0;
			retReq <= 1'b0;
		end
		else
		begin
			if (wrStrobe && (adrs.regs.sel == UsiPkg::PwmPeriod))
				period <= usiWd[15:0];
			if (wrStrobe && (adrs.regs.sel == UsiPkg::PwmDuty))
				duty <= usiWd[15:0];
			// Wrap at period, a zero period parks the counter
			if ((period == '0) || (cnt >= period - 16'd1))
				cnt <= '0;
			else
				cnt <= cnt + 16'd1;
			// Duty at or above period gives a constant high
			pwmOut <= (cnt < duty);
			if (retReq)
			begin
				if (retGnt)
					retReq <= 1'b0;
			end
			else if (rdStrobe)
				retReq <= 1'b1;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (!retReq && rdStrobe)
			retData <= readWord;
	end

endmodule

//--- src/UsiSram.sv
module UsiSram
(
	input  logic        iSysClk,
	input  logic        rst,
	input  logic [31:0] usiWd,
	input  logic [31:0] usiAdrs,
	input  logic        usiCke,
	input  logic        retGnt,
	output logic        retReq,
	output logic [31:0] retData,
	output logic        usiRdy
);

	UsiPkg::UsiAdrs_u adrs;
	// Word storage
	logic [31:0] mem [UsiPkg::SramDepth];
	logic rdStrobe;
	logic wrStrobe;

	// Memory view picks the word index
	assign adrs = usiAdrs;
	assign rdStrobe = usiCke && adrs.mem.rd;
	assign wrStrobe = usiCke && !adrs.mem.rd;
	assign usiRdy = !retReq;

	// Return request held until granted
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			retReq <= 1'b0;
		else if (retReq)
		begin
			if (retGnt)
				retReq <= 1'b0;
		end
		else if (rdStrobe)
			retReq <= 1'b1;
	end

	always_ff @(posedge iSysClk)
	begin
		if (wrStrobe)
			mem[adrs.mem.idx] <= usiWd;
		// Reply word stays put while the request waits
		if (!retReq && rdStrobe)
			retData <= mem[adrs.mem.idx];
	end

endmodule

//--- src/MicroControllerCsr.sv
module MicroControllerCsr
(
	input  logic                          iSysClk,
	input  logic                          rst,
	input  logic [31:0]                   iWd,
	input  logic [7:0]                    iAdrs,
	input  logic                          iCke,
	output logic [31:0]                   oRd,
	output logic [31:0]                   usiWd,
	output logic [31:0]                   usiAdrs,
	output logic [UsiPkg::SlaveCount-1:0] usiCke,
	input  logic [31:0]                   usiRd,
	input  logic [UsiPkg::SlaveCount-1:0] usiRdCke,
	input  logic [UsiPkg::SlaveCount-1:0] usiRdy
);

	// Enables waiting for a ready slave
	logic [UsiPkg::SlaveCount-1:0] pend;
	// Read requests issued but not yet returned
	logic [UsiPkg::SlaveCount-1:0] inFlight;
	// Sticky return flags
	logic [UsiPkg::SlaveCount-1:0] done;
	logic [UsiPkg::SlaveCount-1:0] ckeSet;
	logic [UsiPkg::SlaveCount-1:0] canIssue;
	logic [UsiPkg::SlaveCount-1:0] issueSel;
	// Last word from each slave
	logic [31:0] gpioRd;
	logic [31:0] pwmRd;
	logic [31:0] sramRd;
	logic wdWrite;
	logic adrsWrite;
	logic ckeWrite;

	// --------------------
	// Manual write decode
	// --------------------
	assign wdWrite = iCke && (iAdrs == UsiPkg::CsrWd);
	assign adrsWrite = iCke && (iAdrs == UsiPkg::CsrAdrs);
	assign ckeWrite = iCke && (iAdrs == UsiPkg::CsrCke);
	assign ckeSet = ckeWrite ? iWd[UsiPkg::SlaveCount-1:0] : '0;

	// Skip a slave strobed last cycle, its ready level lags by one
	assign canIssue = pend & usiRdy & ~usiCke;

	// Lowest ready index wins
	always_comb
	begin
		issueSel = '0;
		for (int i = UsiPkg::SlaveCount - 1; i >= 0; i--)
		begin
			if (canIssue[i])
			begin
				issueSel = '0;
				issueSel[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			usiWd <= '0;
			usiAdrs <= '0;
			pend <= '0;
			usiCke <= '0;
			inFlight <= '0;
			done <= '0;
		end
		else
		begin
			if (wdWrite)
				usiWd <= iWd;
			if (adrsWrite)
				usiAdrs <= iWd;
			// Auto-clear as each strobe goes out
			pend <= (pend & ~issueSel) | ckeSet;
			usiCke <= issueSel;
			inFlight <= (inFlight & ~usiRdCke)
				| (issueSel & {UsiPkg::SlaveCount{usiAdrs[UsiPkg::UsiReadBit]}});
			// New enable restarts the done flag
			done <= (done & ~ckeSet) | usiRdCke;
		end
	end

	// --------------------
	// Auto capture
	// --------------------
	always_ff @(posedge iSysClk)
	begin
		if (usiRdCke[UsiPkg::SlaveGpio])
			gpioRd <= usiRd;
		if (usiRdCke[UsiPkg::SlavePwm])
			pwmRd <= usiRd;
		if (usiRdCke[UsiPkg::SlaveSram])
			sramRd <= usiRd;
	end

	// Registered read, one cycle after address
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			oRd <= '0;
		else
		begin
			case (iAdrs)
				UsiPkg::CsrWd:     oRd <= usiWd;
				UsiPkg::CsrAdrs:   oRd <= usiAdrs;
				UsiPkg::CsrCke:    oRd <= 32'(pend);
				UsiPkg::CsrPend:   oRd <= 32'(pend | inFlight);
				UsiPkg::CsrGpioRd: oRd <= gpioRd;
				UsiPkg::CsrPwmRd:  oRd <= pwmRd;
				UsiPkg::CsrSramRd: oRd <= sramRd;
				UsiPkg::CsrDone:   oRd <= 32'(done);
				UsiPkg::CsrRdy:    oRd <= 32'(usiRdy);
				default:           oRd <= '0;
			endcase
		end
	end

	// Strobes leave one at a time
	aCkeOneHot: assert property (@(posedge iSysClk) disable iff (rst) $onehot0(usiCke));
	// Target was ready in the cycle the strobe was chosen
	aCkeReady: assert property (@(posedge iSysClk) disable iff (rst)
		(usiCke & ~$past(usiRdy)) == '0);

endmodule

//--- src/UsiSubsystem.sv
module UsiSubsystem
(
	input  logic        iSysClk,
	input  logic        rst,
	input  logic [31:0] iWd,
	input  logic [7:0]  iAdrs,
	input  logic        iCke,
	output logic [31:0] oRd,
	input  logic [7:0]  gpioIn,
	output logic [7:0]  gpioOut,
	output logic        pwmOut
);

	// --------------------
	// Request path
	// --------------------
	logic [31:0] usiWd;
	logic [31:0] usiAdrs;
	logic [UsiPkg::SlaveCount-1:0] usiCke;
	logic [UsiPkg::SlaveCount-1:0] usiRdy;

	// --------------------
	// Return path
	// --------------------
	logic [UsiPkg::SlaveCount-1:0] retReq;
	logic [UsiPkg::SlaveCount-1:0] retGnt;
	logic [31:0] gpioRetData;
	logic [31:0] pwmRetData;
	logic [31:0] sramRetData;
	logic [31:0] usiRd;
	logic [UsiPkg::SlaveCount-1:0] usiRdCke;

	MicroControllerCsr MicroControllerCsr_inst (.iSysClk(iSysClk), .rst(rst), .iWd(iWd),
		.iAdrs(iAdrs), .iCke(iCke), .oRd(oRd), .usiWd(usiWd), .usiAdrs(usiAdrs),
		.usiCke(usiCke), .usiRd(usiRd), .usiRdCke(usiRdCke), .usiRdy(usiRdy));

	// Shared return bus
	UsiReturnArbiter UsiReturnArbiter_inst (.iSysClk(iSysClk), .rst(rst), .retReq(retReq),
		.gpioRetData(gpioRetData), .pwmRetData(pwmRetData), .sramRetData(sramRetData),
		.retGnt(retGnt), .usiRd(usiRd), .usiRdCke(usiRdCke));

	// Each slave takes its own bit of the per-slave vectors
	UsiGpio UsiGpio_inst (.iSysClk(iSysClk), .rst(rst), .usiWd(usiWd), .usiAdrs(usiAdrs),
		.usiCke(usiCke[UsiPkg::SlaveGpio]), .retGnt(retGnt[UsiPkg::SlaveGpio]),
		.gpioIn(gpioIn), .gpioOut(gpioOut), .retReq(retReq[UsiPkg::SlaveGpio]),
		.retData(gpioRetData), .usiRdy(usiRdy[UsiPkg::SlaveGpio]));

	UsiPwm UsiPwm_inst (.iSysClk(iSysClk), .rst(rst), .usiWd(usiWd), .usiAdrs(usiAdrs),
		.usiCke(usiCke[UsiPkg::SlavePwm]), .retGnt(retGnt[UsiPkg::SlavePwm]),
		.retReq(retReq[UsiPkg::SlavePwm]), .retData(pwmRetData),
		.usiRdy(usiRdy[UsiPkg::SlavePwm]), .pwmOut(pwmOut));

	UsiSram UsiSram_inst (.iSysClk(iSysClk), .rst(rst), .usiWd(usiWd), .usiAdrs(usiAdrs),
		.usiCke(usiCke[UsiPkg::SlaveSram]), .retGnt(retGnt[UsiPkg::SlaveSram]),
		.retReq(retReq[UsiPkg::SlaveSram]), .retData(sramRetData),
		.usiRdy(usiRdy[UsiPkg::SlaveSram]));

endmodule

//--- testbench/UsiSubsystemTb.sv
module UsiSubsystemTb;

	timeunit 1ns;
	timeprecision 100ps;

	// Run limit, about twice the length of all sequences
	localparam int CycleLimit = 4000;
	// Longest wait for a CSR bit or word
	localparam int PollLimit = 50;
	localparam int SramWrites = 32;
	// One-hot enables per slave
	localparam logic [2:0] GpioBit = 3'(1 << UsiPkg::SlaveGpio);
	localparam logic [2:0] PwmBit = 3'(1 << UsiPkg::SlavePwm);
	localparam logic [2:0] SramBit = 3'(1 << UsiPkg::SlaveSram);

	logic iSysClk = 1'b0;
	logic rst;
	logic [31:0] iWd;
	logic [7:0] iAdrs;
	logic iCke;
	logic [31:0] oRd;
	logic [7:0] gpioIn;
	logic [7:0] gpioOut;
	logic pwmOut;

	// Reference model state
	logic [31:0] sramModel [UsiPkg::SramDepth];
	logic [7:0] gpioOutModel;
	logic [7:0] gpioInModel;
	logic [15:0] pwmPeriodModel;
	logic [15:0] pwmDutyModel;

	logic [31:0] rngState = 32'h5ad6_ed2e;
	int cycleCount = 0;

	UsiSubsystem UsiSubsystem_inst (.iSysClk(iSysClk), .rst(rst), .iWd(iWd), .iAdrs(iAdrs),
		.iCke(iCke), .oRd(oRd), .gpioIn(gpioIn), .gpioOut(gpioOut), .pwmOut(pwmOut));

	// 40 ns period
	always #20 iSysClk = ~iSysClk;

	// Hard stop for a hung run
	always @(posedge iSysClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("Run did not finish within %0d clock cycles", CycleLimit);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	// --------------------
	// Random source
	// --------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// --------------------
	// Reference model
	// --------------------

	// Word a slave should hand back for a read of adrs
	function automatic logic [31:0] expectedReturn(input int slave, input logic [31:0] adrs);
		logic [31:0] word;
		word = '0;
		case (slave)
			UsiPkg::SlaveGpio:
			begin
				if (adrs[3:0] == UsiPkg::GpioOut)
					word = {24'b0, gpioOutModel};
				else if (adrs[3:0] == UsiPkg::GpioIn)
					word = {24'b0, gpioInModel};
			end
			UsiPkg::SlavePwm:
			begin
				if (adrs[3:0] == UsiPkg::PwmPeriod)
					word = {16'b0, pwmPeriodModel};
				else if (adrs[3:0] == UsiPkg::PwmDuty)
					word = {16'b0, pwmDutyModel};
			end
			UsiPkg::SlaveSram:
				word = sramModel[adrs[5:0]];
			default:
				word = '0;
		endcase
		return word;
	endfunction

	// Unsolicited GPIO report, marker in bit 31
	function automatic logic [31:0] changeReport(input logic [7:0] pins);
		return {1'b1, 23'b0, pins};
	endfunction

	task automatic compareWord(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
		begin
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// --------------------
	// Processor side
	// --------------------
	task automatic csrWrite(input logic [7:0] adrs, input logic [31:0] data);
		@(posedge iSysClk);
		iCke <= 1'b1;
		iAdrs <= adrs;
		iWd <= data;
		@(posedge iSysClk);
		iCke <= 1'b0;
	endtask

	// Data is registered one edge after the address
	task automatic csrRead(input logic [7:0] adrs, output logic [31:0] data);
		@(posedge iSysClk);
		iAdrs <= adrs;
		@(posedge iSysClk);
		@(negedge iSysClk);
		data = oRd;
	endtask

	task automatic busIssue(input logic [2:0] cke, input logic [31:0] adrs,
		input logic [31:0] data);
		csrWrite(UsiPkg::CsrWd, data);
		csrWrite(UsiPkg::CsrAdrs, adrs);
		csrWrite(UsiPkg::CsrCke, 32'(cke));
	endtask

	// Poll a CSR word until the masked bits match
	task automatic waitForWord(input logic [7:0] adrs, input logic [31:0] mask,
		input logic [31:0] value, input string what);
		logic [31:0] word;
		int waited;
		waited = 0;
		csrRead(adrs, word);
		while ((word & mask) !== value)
		begin
			waited += 2;
			if (waited > PollLimit)
			begin
				$display("Gave up after %0d cycles waiting for %s", PollLimit, what);
				$display("Checks failed");
				$fatal(1, "poll timeout");
			end
			csrRead(adrs, word);
		end
	endtask

	initial
	begin
		logic [31:0] word;
		logic [31:0] adrs;
		logic [31:0] data;
		logic [5:0] idxList [SramWrites];
		logic [7:0] newIn;
		logic [15:0] period;
		logic [15:0] duty;
		int highCount;

		rst = 1'b1;
		iWd = '0;
		iAdrs = '0;
		iCke = 1'b0;
		gpioIn = '0;
		gpioInModel = '0;
		repeat (8) @(posedge iSysClk);
		rst <= 1'b0;

		// --------------------
		// CSR registers
		// --------------------
		csrRead(UsiPkg::CsrRdy, word);
		compareWord(word, 32'd7, "ready levels after reset");
		data = nextRand();
		csrWrite(UsiPkg::CsrWd, data);
		csrRead(UsiPkg::CsrWd, word);
		compareWord(word, data, "write data register");
		data = nextRand();
		csrWrite(UsiPkg::CsrAdrs, data);
		csrRead(UsiPkg::CsrAdrs, word);
		compareWord(word, data, "bus address register");

		// --------------------
		// SRAM
		// --------------------
		for (int i = 0; i < SramWrites; i++)
		begin
			data = nextRand();
			// Pad bits stay random, only the index matters
			adrs = nextRand();
			adrs[UsiPkg::UsiReadBit] = 1'b0;
			idxList[i] = adrs[5:0];
			sramModel[adrs[5:0]] = data;
			busIssue(SramBit, adrs, data);
			waitForWord(UsiPkg::CsrPend, 32'(SramBit), '0, "SRAM write to leave");
		end
		// Enable word empties itself once issued
		csrRead(UsiPkg::CsrCke, word);
		compareWord(word, '0, "enable word after issue");
		for (int i = 0; i < SramWrites; i++)
		begin
			adrs = nextRand();
			adrs[UsiPkg::UsiReadBit] = 1'b1;
			adrs[5:0] = idxList[i];
			busIssue(SramBit, adrs, nextRand());
			waitForWord(UsiPkg::CsrDone, 32'(SramBit), 32'(SramBit), "SRAM read return");
			csrRead(UsiPkg::CsrSramRd, word);
			compareWord(word, expectedReturn(UsiPkg::SlaveSram, adrs), "SRAM read word");
		end

		// --------------------
		// GPIO
		// --------------------
		data = nextRand();
		adrs = 32'(UsiPkg::GpioOut);
		gpioOutModel = data[7:0];
		busIssue(GpioBit, adrs, data);
		waitForWord(UsiPkg::CsrPend, 32'(GpioBit), '0, "GPIO write to leave");
		@(negedge iSysClk);
		compareWord(32'(gpioOut), 32'(gpioOutModel), "gpioOut pins");
		// No GPIO return yet, so only the report can set its done bit
		// Any nonzero value differs from the reset level
		word = nextRand();
		newIn = word[7:0] | 8'h01;
		@(posedge iSysClk);
		gpioIn <= newIn;
		gpioInModel = newIn;
		waitForWord(UsiPkg::CsrGpioRd, '1, changeReport(newIn), "GPIO change report");
		csrRead(UsiPkg::CsrDone, word);
		compareWord(word & 32'(GpioBit), 32'(GpioBit), "GPIO done bit after report");
		adrs[UsiPkg::UsiReadBit] = 1'b1;
		busIssue(GpioBit, adrs, '0);
		waitForWord(UsiPkg::CsrDone, 32'(GpioBit), 32'(GpioBit), "GPIO read return");
		csrRead(UsiPkg::CsrGpioRd, word);
		compareWord(word, expectedReturn(UsiPkg::SlaveGpio, adrs), "GPIO output readback");
		adrs = 32'(UsiPkg::GpioIn);
		adrs[UsiPkg::UsiReadBit] = 1'b1;
		busIssue(GpioBit, adrs, '0);
		waitForWord(UsiPkg::CsrDone, 32'(GpioBit), 32'(GpioBit), "GPIO input return");
		csrRead(UsiPkg::CsrGpioRd, word);
		compareWord(word, expectedReturn(UsiPkg::SlaveGpio, adrs), "GPIO input readback");

		// --------------------
		// PWM
		// --------------------
		// First pass duty below period, second at or above
		for (int pass = 0; pass < 2; pass++)
		begin
			word = nextRand();
			period = 16'd4 + 16'(word[3:0]);
			if (pass == 0)
				duty = 16'(word[8:4]) % period;
			else
				duty = period + 16'(word[10:9]);
			pwmPeriodModel = period;
			pwmDutyModel = duty;
			busIssue(PwmBit, 32'(UsiPkg::PwmPeriod), 32'(period));
			waitForWord(UsiPkg::CsrPend, 32'(PwmBit), '0, "PWM period write");
			busIssue(PwmBit, 32'(UsiPkg::PwmDuty), 32'(duty));
			waitForWord(UsiPkg::CsrPend, 32'(PwmBit), '0, "PWM duty write");
			for (int sel = 0; sel < 2; sel++)
			begin
				adrs = 32'(sel);
				adrs[UsiPkg::UsiReadBit] = 1'b1;
				busIssue(PwmBit, adrs, '0);
				waitForWord(UsiPkg::CsrDone, 32'(PwmBit), 32'(PwmBit), "PWM read return");
				csrRead(UsiPkg::CsrPwmRd, word);
				compareWord(word, expectedReturn(UsiPkg::SlavePwm, adrs), "PWM readback");
			end
			// Three whole periods
			highCount = 0;
			repeat (3 * int'(period))
			begin
				@(negedge iSysClk);
				if (pwmOut)
					highCount++;
			end
			compareWord(32'(highCount), 32'(3 * int'((duty < period) ? duty : period)),
				"PWM high cycles over three periods");
		end

		// --------------------
		// Contention
		// --------------------
		// Fresh GPIO enable drops its done bit ahead of the collision
		busIssue(GpioBit, 32'(UsiPkg::GpioOut), 32'(gpioOutModel));
		waitForWord(UsiPkg::CsrPend, 32'(GpioBit), '0, "GPIO write to leave");
		csrRead(UsiPkg::CsrDone, word);
		compareWord(word & 32'(GpioBit), '0, "GPIO done bit after new enable");
		// Index 21h also selects the PWM duty register
		data = nextRand();
		adrs = 32'h0000_0021;
		sramModel[6'h21] = data;
		busIssue(SramBit, adrs, data);
		waitForWord(UsiPkg::CsrPend, 32'(SramBit), '0, "SRAM write to leave");
		adrs[UsiPkg::UsiReadBit] = 1'b1;
		csrWrite(UsiPkg::CsrAdrs, adrs);
		word = nextRand();
		newIn = gpioInModel ^ (word[7:0] | 8'h01);
		// Pin change lands with the enable write so all three returns collide
		@(posedge iSysClk);
		iCke <= 1'b1;
		iAdrs <= UsiPkg::CsrCke;
		iWd <= 32'(PwmBit | SramBit);
		gpioIn <= newIn;
		gpioInModel = newIn;
		@(posedge iSysClk);
		iCke <= 1'b0;
		waitForWord(UsiPkg::CsrDone, 32'(PwmBit | SramBit), 32'(PwmBit | SramBit),
			"PWM and SRAM returns under contention");
		waitForWord(UsiPkg::CsrGpioRd, '1, changeReport(newIn), "GPIO report under contention");
		csrRead(UsiPkg::CsrDone, word);
		compareWord(word, 32'd7, "all done bits");
		csrRead(UsiPkg::CsrPwmRd, word);
		compareWord(word, expectedReturn(UsiPkg::SlavePwm, adrs), "PWM word under contention");
		csrRead(UsiPkg::CsrSramRd, word);
		compareWord(word, expectedReturn(UsiPkg::SlaveSram, adrs), "SRAM word under contention");

		$display("All checks passed");
		$finish;
	end

endmodule

//--- tb.f
src/UsiPkg.sv
src/UsiReturnArbiter.sv
src/UsiGpio.sv
src/UsiPwm.sv
src/UsiSram.sv
src/MicroControllerCsr.sv
src/UsiSubsystem.sv
testbench/UsiSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, exit status is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module UsiSubsystemTb -f tb.f -o UsiSubsystemTb

./obj_dir/UsiSubsystemTb
